//--- bank_q_params.svh
`ifndef BANK_Q_PARAMS_SVH
`define BANK_Q_PARAMS_SVH

// ------------------------------------------------------------
// bank structure
// ------------------------------------------------------------

// number of banks and bank queues, power of two
`define BANK_Q_NUM_BANKS 4
// bank index width, log2 of the bank count
`define BANK_Q_BANK_W 2
// entries per bank queue
`define BANK_Q_DEPTH 4

// ------------------------------------------------------------
// request fields
// ------------------------------------------------------------

`define BANK_Q_ADDR_W 32
`define BANK_Q_DATA_W 32
`define BANK_Q_TAG_W 4

`endif

//--- bank_q_pkg.sv
`include "bank_q_params.svh"

package bank_q_pkg;

    // ------------------------------------------------------------
    // request types
    // ------------------------------------------------------------

    // one request from the requester side
    typedef struct packed {
        logic [`BANK_Q_ADDR_W-1:0] addr;
        logic [`BANK_Q_DATA_W-1:0] data;
        // requester id, carried through untouched
        logic [`BANK_Q_TAG_W-1:0]  tag;
    } mem_req_t;

    // request leaving the buffer, with the bank that served it
    typedef struct packed {
        logic [`BANK_Q_BANK_W-1:0] bank;
        mem_req_t                  req;
    } bank_req_t;

    // ------------------------------------------------------------
    // widths for convenience
    // ------------------------------------------------------------

    localparam int MEM_REQ_W  = $bits(mem_req_t);
    localparam int BANK_REQ_W = $bits(bank_req_t);

endpackage

//--- q_fast_ready.sv
`timescale 1ns/1ns

module q_fast_ready #(
    parameter type DATA_T = logic [31:0],
    parameter int NUM_ENTRIES = 4
) (
    input  logic  CLK,
    input  logic  nRST,

    // enqueue side
    input  logic  enq_valid,
    input  DATA_T enq_data,
    output logic  enq_ready,

    // dequeue side
    output logic  deq_valid,
    output DATA_T deq_data,
    input  logic  deq_ready
);

    // pointer width, at least one bit
    localparam int PTR_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;

    // ------------------------------------------------------------
    // storage and pointers
    // ------------------------------------------------------------

    DATA_T q_entries [NUM_ENTRIES];

    logic [PTR_W-1:0] enq_ptr;
    logic [PTR_W-1:0] enq_ptr_next;
    logic [PTR_W-1:0] deq_ptr;
    logic [PTR_W-1:0] deq_ptr_next;

    logic enq_fire;
    logic deq_fire;

    assign enq_fire = enq_valid & enq_ready;
    assign deq_fire = deq_valid & deq_ready;

    // wrap explicitly so non power of two depths work too
    assign enq_ptr_next = (enq_ptr == PTR_W'(NUM_ENTRIES - 1)) ? '0 : enq_ptr + PTR_W'(1);
    assign deq_ptr_next = (deq_ptr == PTR_W'(NUM_ENTRIES - 1)) ? '0 : deq_ptr + PTR_W'(1);

    assign deq_data = q_entries[deq_ptr];

    // ------------------------------------------------------------
    // entry write
    // ------------------------------------------------------------

    always_ff @(posedge CLK) begin
        if (enq_fire) begin
            q_entries[enq_ptr] <= enq_data;
        end
    end

    // ------------------------------------------------------------
    // pointers and registered handshake
    // ------------------------------------------------------------

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            enq_ptr   <= '0;
            deq_ptr   <= '0;
            enq_ready <= 1'b1;
            deq_valid <= 1'b0;
        end else begin
            if (enq_fire) begin
                enq_ptr <= enq_ptr_next;
            end
            if (deq_fire) begin
                deq_ptr <= deq_ptr_next;
            end

            // enqueue only, full once the write pointer meets the read pointer
            if (enq_fire && !deq_fire) begin
                enq_ready <= (enq_ptr_next != deq_ptr);
                deq_valid <= 1'b1;
            end

            // dequeue only, empty once the read pointer catches up
            if (deq_fire && !enq_fire) begin
                enq_ready <= 1'b1;
                deq_valid <= (deq_ptr_next != enq_ptr);
            end
            // both at once leaves the occupancy unchanged
        end
    end

endmodule

//--- bank_steer.sv
`timescale 1ns/1ns
`include "bank_q_params.svh"

module bank_steer (
    // incoming request stream
    input  logic                         req_valid,
    input  bank_q_pkg::mem_req_t         req,
    output logic                         req_ready,

    // per bank queue enqueue ports
    output logic [`BANK_Q_NUM_BANKS-1:0] enq_valid,
    output bank_q_pkg::mem_req_t         enq_data,
    input  logic [`BANK_Q_NUM_BANKS-1:0] enq_ready
);

    localparam int NUM_BANKS = `BANK_Q_NUM_BANKS;
    localparam int BANK_W    = `BANK_Q_BANK_W;

    logic [BANK_W-1:0] bank_sel;

    // ------------------------------------------------------------
    // bank hash
    // ------------------------------------------------------------

    // fold two address fields so strided streams spread out
    assign bank_sel = req.addr[3:2] ^ req.addr[5:4];

    // ------------------------------------------------------------
    // routing
    // ------------------------------------------------------------

    // payload goes to every queue, only the selected one sees valid
    assign enq_data = req;

    always_comb begin
        enq_valid = '0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (bank_sel == BANK_W'(i)) begin
                enq_valid[i] = req_valid;
            end
        end
    end

    // ready follows the selected queue only
    assign req_ready = enq_ready[bank_sel];

endmodule

//--- rr_drain.sv
`timescale 1ns/1ns
`include "bank_q_params.svh"

module rr_drain (
    input  logic                                                CLK,
    input  logic                                                nRST,

    // bank queue dequeue ports
    input  logic [`BANK_Q_NUM_BANKS-1:0]                        deq_valid,
    input  bank_q_pkg::mem_req_t [`BANK_Q_NUM_BANKS-1:0]        deq_data,
    output logic [`BANK_Q_NUM_BANKS-1:0]                        deq_ready,

    // merged output stream
    output logic                                                out_valid,
    output bank_q_pkg::bank_req_t                               out,
    input  logic                                                out_ready
);

    localparam int NUM_BANKS = `BANK_Q_NUM_BANKS;
    localparam int BANK_W    = `BANK_Q_BANK_W;

    // bank with top priority this cycle
    logic [BANK_W-1:0] rr_ptr;

    logic [BANK_W-1:0] grant_idx;
    logic              grant_found;

    // ------------------------------------------------------------
    // grant search
    // ------------------------------------------------------------

    // first valid bank at or after the pointer, index wraps by width
    always_comb begin
        logic [BANK_W-1:0] idx;
        grant_found = 1'b0;
        grant_idx   = rr_ptr;
        for (int i = 0; i < NUM_BANKS; i++) begin
            idx = rr_ptr + BANK_W'(i);
            if (!grant_found && deq_valid[idx]) begin
                grant_found = 1'b1;
                grant_idx   = idx;
            end
        end
    end

    // ------------------------------------------------------------
    // output mux and dequeue
    // ------------------------------------------------------------

    assign out_valid = grant_found;
    assign out.bank  = grant_idx;
    assign out.req   = deq_data[grant_idx];

    always_comb begin
        deq_ready = '0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            deq_ready[i] = grant_found && out_ready && (grant_idx == BANK_W'(i));
        end
    end

    // ------------------------------------------------------------
    // priority pointer
    // ------------------------------------------------------------

    // advance past the winner only when the output actually moves
    always_ff @(posedge CLK) begin
        if (!nRST) begin
            rr_ptr <= '0;
        end else if (out_valid && out_ready) begin
            rr_ptr <= grant_idx + BANK_W'(1);
        end
    end

endmodule

//--- bank_q_top.sv
`timescale 1ns/1ns
`include "bank_q_params.svh"

module bank_q_top (
    input  logic                  CLK,
    input  logic                  nRST,

    // request input
    input  logic                  req_valid,
    input  bank_q_pkg::mem_req_t  req,
    output logic                  req_ready,

    // tagged request output
    output logic                  out_valid,
    output bank_q_pkg::bank_req_t out,
    input  logic                  out_ready
);

    // ------------------------------------------------------------
    // internal handshakes
    // ------------------------------------------------------------

    logic [`BANK_Q_NUM_BANKS-1:0]                 enq_valid;
    bank_q_pkg::mem_req_t                         enq_data;
    logic [`BANK_Q_NUM_BANKS-1:0]                 enq_ready;

    logic [`BANK_Q_NUM_BANKS-1:0]                 deq_valid;
    bank_q_pkg::mem_req_t [`BANK_Q_NUM_BANKS-1:0] deq_data;
    logic [`BANK_Q_NUM_BANKS-1:0]                 deq_ready;

    // ------------------------------------------------------------
    // steer, bank queues, drain
    // ------------------------------------------------------------

    bank_steer steer_i (
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .enq_valid (enq_valid),
        .enq_data  (enq_data),
        .enq_ready (enq_ready)
    );

    for (genvar b = 0; b < `BANK_Q_NUM_BANKS; b++) begin : g_bank
        q_fast_ready #(
            .DATA_T      (bank_q_pkg::mem_req_t),
            .NUM_ENTRIES (`BANK_Q_DEPTH)
        ) q_i (
            .CLK       (CLK),
            .nRST      (nRST),
            .enq_valid (enq_valid[b]),
            .enq_data  (enq_data),
            .enq_ready (enq_ready[b]),
            .deq_valid (deq_valid[b]),
            .deq_data  (deq_data[b]),
            .deq_ready (deq_ready[b])
        );
    end

    rr_drain drain_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .deq_valid (deq_valid),
        .deq_data  (deq_data),
        .deq_ready (deq_ready),
        .out_valid (out_valid),
        .out       (out),
        .out_ready (out_ready)
    );

endmodule

//--- tb_bank_q_top.sv
`timescale 1ns/1ns
`include "bank_q_params.svh"

module tb_bank_q_top;

    localparam int NUM_STIM      = 26;
    localparam int ROT_LEN       = 8;
    localparam int REQ_TIMEOUT   = 200;
    localparam int DRAIN_TIMEOUT = 500;

    // out_ready modes
    localparam int MODE_LOW    = 0;
    localparam int MODE_HIGH   = 1;
    localparam int MODE_RANDOM = 2;

    // one table row
    // probe rows are only offered and never handed over
    typedef struct packed {
        logic [`BANK_Q_ADDR_W-1:0] addr;
        logic [`BANK_Q_DATA_W-1:0] data;
        logic [`BANK_Q_TAG_W-1:0]  tag;
        logic                      hold;
        logic                      probe;
        logic [`BANK_Q_BANK_W-1:0] bank;
    } stim_t;

    logic                  CLK;
    logic                  nRST;
    logic                  req_valid;
    bank_q_pkg::mem_req_t  req;
    logic                  req_ready;
    logic                  out_valid;
    bank_q_pkg::bank_req_t out;
    logic                  out_ready = 1'b0;

    int out_mode = MODE_LOW;

    // expected requests per bank
    bank_q_pkg::mem_req_t exp_q [`BANK_Q_NUM_BANKS][$];
    logic [`BANK_Q_BANK_W-1:0] out_banks [$];

    // bank column worked out by hand from addr[3:2] ^ addr[5:4]
    stim_t stim [NUM_STIM] = '{
        '{32'h0000_0104, 32'hA000_0001, 4'h1, 1'b1, 1'b0, 2'd1},
        '{32'h0000_0210, 32'hA000_0002, 4'h2, 1'b1, 1'b0, 2'd1},
        '{32'h0000_032C, 32'hA000_0003, 4'h3, 1'b1, 1'b0, 2'd1},
        '{32'h0000_0438, 32'hA000_0004, 4'h4, 1'b1, 1'b0, 2'd1},
        '{32'h0000_0504, 32'hA000_0005, 4'h5, 1'b1, 1'b1, 2'd1},
        '{32'h0000_2008, 32'hB000_0001, 4'h6, 1'b1, 1'b0, 2'd2},
        '{32'h0000_1000, 32'hC000_0001, 4'h7, 1'b1, 1'b0, 2'd0},
        '{32'h0000_201C, 32'hB000_0002, 4'h8, 1'b1, 1'b0, 2'd2},
        '{32'h0000_300C, 32'hD000_0001, 4'h9, 1'b1, 1'b0, 2'd3},
        '{32'h0000_0000, 32'h1234_5678, 4'hA, 1'b0, 1'b0, 2'd0},
        '{32'h0000_0044, 32'h0000_0044, 4'hB, 1'b0, 1'b0, 2'd1},
        '{32'h0000_0088, 32'h0000_0088, 4'hC, 1'b0, 1'b0, 2'd2},
        '{32'h0000_00CC, 32'h0000_00CC, 4'hD, 1'b0, 1'b0, 2'd3},
        '{32'h0000_0014, 32'h5555_0014, 4'hE, 1'b0, 1'b0, 2'd0},
        '{32'h0000_0010, 32'h5555_0010, 4'hF, 1'b0, 1'b0, 2'd1},
        '{32'h0000_0020, 32'h5555_0020, 4'h0, 1'b0, 1'b0, 2'd2},
        '{32'h0000_0030, 32'h5555_0030, 4'h1, 1'b0, 1'b0, 2'd3},
        '{32'h0000_1104, 32'h6666_0001, 4'h2, 1'b0, 1'b0, 2'd1},
        '{32'h0000_1238, 32'h6666_0002, 4'h3, 1'b0, 1'b0, 2'd1},
        '{32'h0000_132C, 32'h6666_0003, 4'h4, 1'b0, 1'b0, 2'd1},
        '{32'h0000_1404, 32'h6666_0004, 4'h5, 1'b0, 1'b0, 2'd1},
        '{32'h0000_1510, 32'h6666_0005, 4'h6, 1'b0, 1'b0, 2'd1},
        '{32'h0000_2034, 32'h7777_2034, 4'h7, 1'b0, 1'b0, 2'd2},
        '{32'h0000_3024, 32'h7777_3024, 4'h8, 1'b0, 1'b0, 2'd3},
        '{32'h0000_403C, 32'h7777_403C, 4'h9, 1'b0, 1'b0, 2'd0},
        '{32'hDEAD_BEEF, 32'hCAFE_F00D, 4'hA, 1'b0, 1'b0, 2'd1}
    };

    // drain order of the held rows with the pointer starting at bank 0
    logic [`BANK_Q_BANK_W-1:0] rot_expect [ROT_LEN] = '{
        2'd0, 2'd1, 2'd2, 2'd3, 2'd1, 2'd2, 2'd1, 2'd1
    };

    bank_q_top dut_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .out_valid (out_valid),
        .out       (out),
        .out_ready (out_ready)
    );

    initial CLK = 1'b0;
    always #5 CLK = ~CLK;

    // out_ready follows the current mode 1 ns after each edge
    always @(posedge CLK) begin
        #1;
        case (out_mode)
            MODE_LOW:  out_ready <= 1'b0;
            MODE_HIGH: out_ready <= 1'b1;
            default:   out_ready <= 1'($urandom);
        endcase
    end

    // ------------------------------------------------------------
    // reporting
    // ------------------------------------------------------------

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED: %s got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    function automatic int pending();
        int n;
        n = 0;
        for (int b = 0; b < `BANK_Q_NUM_BANKS; b++) begin
            n += exp_q[b].size();
        end
        return n;
    endfunction

    // ------------------------------------------------------------
    // output monitor
    // ------------------------------------------------------------

    // sampled at the falling edge before the transfer edge
    always @(negedge CLK) begin
        bank_q_pkg::mem_req_t exp_out;
        if (nRST && out_valid && out_ready) begin
            // the reported bank picks the queue, so a misrouted request mismatches
            if (exp_q[out.bank].size() == 0) begin
                fail_run($sformatf("output from bank %0d with no request pending", out.bank));
            end else begin
                exp_out = exp_q[out.bank].pop_front();
                check("out.req.addr", 128'(out.req.addr), 128'(exp_out.addr));
                check("out.req.data", 128'(out.req.data), 128'(exp_out.data));
                check("out.req.tag", 128'(out.req.tag), 128'(exp_out.tag));
                out_banks.push_back(out.bank);
            end
        end
    end

    // ------------------------------------------------------------
    // stimulus tasks
    // ------------------------------------------------------------

    // mode change lands at a falling edge clear of the driver block
    task automatic set_out_mode(input int m);
        @(negedge CLK);
        out_mode = m;
        @(posedge CLK);
        #1;
    endtask

    task automatic send_request(input stim_t s);
        int waited;
        bank_q_pkg::mem_req_t exp_req;
        waited = 0;
        req_valid = 1'b1;
        req.addr  = s.addr;
        req.data  = s.data;
        req.tag   = s.tag;
        exp_req.addr = s.addr;
        exp_req.data = s.data;
        exp_req.tag  = s.tag;
        @(negedge CLK);
        // a held row goes to a bank that is not yet full
        if (s.hold) begin
            check("req_ready", 128'(req_ready), 128'(1'b1));
        end
        while (!req_ready) begin
            waited++;
            if (waited > REQ_TIMEOUT) begin
                fail_run($sformatf("timeout waiting for req_ready, address 0x%0h", s.addr));
            end
            @(negedge CLK);
        end
        exp_q[s.bank].push_back(exp_req);
        @(posedge CLK);
        #1;
        req_valid = 1'b0;
    endtask

    // full bank must refuse while valid stays low
    task automatic probe_full(input stim_t s);
        req_valid = 1'b0;
        req.addr  = s.addr;
        req.data  = s.data;
        req.tag   = s.tag;
        repeat (3) begin
            @(negedge CLK);
            check("req_ready", 128'(req_ready), 128'(1'b0));
        end
        @(posedge CLK);
        #1;
    endtask

    task automatic wait_drained(input string what);
        int waited;
        waited = 0;
        while (pending() != 0) begin
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                fail_run($sformatf("timeout waiting for the banks to drain during %s", what));
            end
            @(posedge CLK);
            #1;
        end
    endtask

    task automatic check_rotation();
        out_banks.delete();
        set_out_mode(MODE_HIGH);
        wait_drained("the round-robin check");
        check("output count", 128'(out_banks.size()), 128'(ROT_LEN));
        for (int i = 0; i < ROT_LEN; i++) begin
            check($sformatf("out.bank[%0d]", i), 128'(out_banks[i]), 128'(rot_expect[i]));
        end
        set_out_mode(MODE_RANDOM);
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------

    initial begin
        void'($urandom(9));
        nRST      = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        repeat (10) @(posedge CLK);
        #1;
        nRST = 1'b1;

        @(negedge CLK);
        check("out_valid", 128'(out_valid), 128'(1'b0));
        check("req_ready", 128'(req_ready), 128'(1'b1));
        @(posedge CLK);
        #1;

        for (int i = 0; i < NUM_STIM; i++) begin
            // leaving a held phase releases the banks in round-robin order
            if (i > 0 && stim[i-1].hold && !stim[i].hold) begin
                check_rotation();
            end
            if (stim[i].probe) begin
                probe_full(stim[i]);
            end else begin
                send_request(stim[i]);
            end
        end

        wait_drained("the final drain");
        @(negedge CLK);
        check("out_valid", 128'(out_valid), 128'(1'b0));

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+.
bank_q_pkg.sv
q_fast_ready.sv
bank_steer.sv
rr_drain.sv
bank_q_top.sv
tb_bank_q_top.sv

//--- Makefile
TOP := tb_bank_q_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f vlog.f --top-module $(TOP) -Mdir obj_dir -o sim

# pass only if the run prints the pass message
run: compile
	@out=$$(./obj_dir/sim); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
